//--- all.f
src/smc_pkg.sv
src/smc_timing_if.sv
src/smc_access_if.sv
src/smc_host_front.sv
src/smc_state.sv
src/smc_counters.sv
src/smc_mac.sv
src/smc_lite.sv
bench/tb_clock.sv
bench/smc_lite_tb.sv

//--- bench/smc_lite_tb.sv
`timescale 1ns/1ns
// Directed testbench for the static memory controller
// 64-byte asynchronous memory model, pin history per cycle and word checks

module smc_lite_tb
  import smc_pkg::*;
();

  localparam int access_max  = lanes * (1 + 3 + (1 << ws_w) + 3) + 8;  // Worst word
  localparam int n_tests     = 6;
  localparam int cycle_limit = n_tests * 4 * access_max;  // Up to 4 words per test

  logic                     sys_clk24;
  logic                     n_sys_reset24;
  logic                     req;
  logic                     rd;
  logic [addr_w-1:0]        addr;
  logic [data_w-1:0]        wdata;
  logic                     busy;
  logic                     done;
  logic [data_w-1:0]        rdata;
  logic [edge_w-1:0]        cfg_csle;
  logic [ws_w-1:0]          cfg_ws;
  logic [edge_w-1:0]        cfg_oete;
  logic [edge_w-1:0]        cfg_cste;
  logic                     mem_cs_n;
  logic                     mem_oe_n;
  logic                     mem_we_n;
  logic [addr_w+lane_w-1:0] mem_addr;
  logic [byte_w-1:0]        mem_wdata;
  logic [byte_w-1:0]        mem_rdata;

  logic [byte_w-1:0] mem [0:63];  // Memory model
  logic [2:0]        hist [$];     // {cs_n, oe_n, we_n} per cycle
  int                run_start [$];
  int                run_len [$];
  logic [15:0]       lfsr;
  bit                recording;
  int                cycles;
  int                errors;
  int                checks;
  int                tests_run;

  tb_clock clock_i (.sys_clk24, .n_sys_reset24);

  smc_lite smc_lite_i (.sys_clk24, .n_sys_reset24, .req, .rd, .addr, .wdata, .busy,
                       .done, .rdata, .cfg_csle, .cfg_ws, .cfg_oete, .cfg_cste,
                       .mem_cs_n, .mem_oe_n, .mem_we_n, .mem_addr, .mem_wdata,
                       .mem_rdata);

  // --------------------
  // Memory model
  // --------------------
  assign mem_rdata = mem_oe_n ? 8'hzz : mem[mem_addr[5:0]];  // Floats when not read

  always @(posedge mem_we_n)
  begin
    if (n_sys_reset24 === 1'b1)
      mem[mem_addr[5:0]] = mem_wdata;  // Byte lands on strobe release
  end

  always @(posedge sys_clk24)
    cycles <= cycles + 1;

  always @(posedge sys_clk24)
  begin
    #2;  // Pins settled, before any mid-cycle strobe cut
    if (recording)
      hist.push_back({mem_cs_n, mem_oe_n, mem_we_n});
  end

  initial
  begin
    wait (cycles >= cycle_limit);
    $display("Run stopped at %0d cycles before the tests finished", cycles);
    $display("*** FAILED ***");
    $finish;
  end

  // --------------------
  // Random source and compare tasks
  // --------------------
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[14] ^ s[12] ^ s[3]};  // x^16+x^15+x^13+x^4+1
  endfunction

  task automatic draw(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = lfsr_next(lfsr);
      v    = {v[30:0], lfsr[0]};  // One step per bit
    end
  endtask

  task automatic check_word(input string name, input logic [data_w-1:0] got, exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_count(input string name, input logic [ws_w:0] got, exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic test_end(input string name, input int err0);
    tests_run++;
    if (errors == err0)
      $display("test %0d %s: ok", tests_run, name);
    else
      $display("test %0d %s: %0d errors", tests_run, name, errors - err0);
  endtask

  // Little-endian word at a word address, aliased into 64 bytes
  function automatic logic [data_w-1:0] model_word(input logic [addr_w-1:0] a);
    return {mem[{a[3:0], 2'd3}], mem[{a[3:0], 2'd2}],
            mem[{a[3:0], 2'd1}], mem[{a[3:0], 2'd0}]};
  endfunction

  // Low spans of one history bit
  task automatic find_runs(input int b);
    int start;
    run_start.delete();
    run_len.delete();
    start = -1;
    for (int i = 0; i <= hist.size(); i++)
    begin
      if (i < hist.size() && !hist[i][b])
      begin
        if (start < 0)
          start = i;
      end
      else if (start >= 0)
      begin
        run_start.push_back(start);
        run_len.push_back(i - start);
        start = -1;
      end
    end
  endtask

  // Cycles with chip select low and both strobes high, walking from one cycle
  function automatic int quiet_span(input int from, input int step);
    int n;
    int i;
    n = 0;
    i = from;
    while (i >= 0 && i < hist.size() && hist[i] === 3'b011)
    begin
      n++;
      i += step;
    end
    return n;
  endfunction

  // --------------------
  // Host side drivers
  // --------------------
  task automatic set_cfg(input logic [edge_w-1:0] csle, input logic [ws_w-1:0] ws,
                         input logic [edge_w-1:0] oete, input logic [edge_w-1:0] cste);
    @(posedge sys_clk24);
    cfg_csle <= csle;
    cfg_ws   <= ws;
    cfg_oete <= oete;
    cfg_cste <= cste;
    #1;
  endtask

  task automatic issue(input logic is_rd, input logic [addr_w-1:0] a,
                       input logic [data_w-1:0] d);
    int n;
    n = 0;
    while (busy !== 1'b0 && n < access_max)  // Full slot drops req
    begin
      @(posedge sys_clk24);
      #1;
      n++;
    end
    if (busy !== 1'b0)
    begin
      errors++;
      $display("Host slot stayed full for %0d cycles", n);
    end
    @(posedge sys_clk24);
    req   <= 1'b1;
    rd    <= is_rd;
    addr  <= a;
    wdata <= d;
    @(posedge sys_clk24);
    req <= 1'b0;
    #1;
  endtask

  task automatic wait_done(output logic [data_w-1:0] word);
    int n;
    n = 1;
    word = 'x;
    @(posedge sys_clk24);
    #1;
    while (done !== 1'b1 && n < access_max)
    begin
      @(posedge sys_clk24);
      #1;
      n++;
    end
    if (done === 1'b1)
      word = rdata;  // Whole word held in the done cycle
    else
    begin
      errors++;
      $display("No done within %0d cycles", n);
    end
  endtask

  task automatic wait_last_lane();
    int n;
    n = 0;
    while ((mem_addr[lane_w-1:0] !== lane_w'(lanes - 1) || mem_cs_n !== 1'b0) &&
           n < access_max)
    begin
      @(posedge sys_clk24);
      #1;
      n++;
    end
    if (n >= access_max)
    begin
      errors++;
      $display("Final byte lane never started");
    end
  endtask

  // --------------------
  // Tests
  // --------------------
  task automatic reset_state_test();
    int err0;
    err0 = errors;
    check_bit("mem_cs_n", mem_cs_n, 1'b1);
    check_bit("mem_oe_n", mem_oe_n, 1'b1);
    check_bit("mem_we_n", mem_we_n, 1'b1);
    check_bit("busy", busy, 1'b0);
    check_bit("done", done, 1'b0);
    test_end("reset state", err0);
  endtask

  task automatic write_read_test();
    logic [31:0]       v;
    logic [addr_w-1:0] a;
    logic [data_w-1:0] d;
    logic [data_w-1:0] word;
    int                err0;
    err0 = errors;
    draw(addr_w, v);
    a = v[addr_w-1:0];
    draw(data_w, v);
    d = v;
    set_cfg(0, 0, 0, 0);
    issue(1'b0, a, d);
    wait_done(word);
    check_bit("mem_cs_n", mem_cs_n, 1'b1);  // Released by done
    issue(1'b1, a, '0);
    wait_done(word);
    check_word("rdata", word, d);
    check_bit("mem_cs_n", mem_cs_n, 1'b1);
    test_end("write then read", err0);
  endtask

  task automatic wait_state_test();
    logic [31:0]       v;
    logic [ws_w-1:0]   ws;
    logic [addr_w-1:0] a;
    logic [data_w-1:0] d;
    logic [data_w-1:0] word;
    int                err0;
    err0 = errors;
    for (int k = 0; k < 2; k++)
    begin
      draw(ws_w, v);
      ws = v[ws_w-1:0];
      draw(addr_w, v);
      a = v[addr_w-1:0];
      draw(data_w, v);
      d = v;
      set_cfg(0, ws, 0, 1);  // Float cycle splits the lanes
      hist.delete();
      recording = 1'b1;
      issue(1'b0, a, d);
      wait_done(word);
      recording = 1'b0;
      find_runs(0);
      check_count("mem_we_n low spans", run_len.size(), lanes);
      foreach (run_len[i])
        check_count("mem_we_n low cycles", run_len[i], ws + 1);
      check_word("memory word", model_word(a), d);
    end
    test_end("wait states", err0);
  endtask

  task automatic edge_timing_test();
    logic [31:0]       v;
    logic [data_w-1:0] d;
    logic [data_w-1:0] word;
    int                last;
    int                err0;
    err0 = errors;
    draw(data_w, v);
    d = v;
    set_cfg(2, 1, 0, 1);
    hist.delete();
    recording = 1'b1;
    issue(1'b0, addr_w'(5), d);
    wait_done(word);
    recording = 1'b0;
    check_bit("mem_cs_n", mem_cs_n, 1'b1);  // Up again once float ends
    find_runs(0);
    check_count("mem_we_n low spans", run_len.size(), lanes);
    foreach (run_start[i])  // Lane 0 has le only, later lanes float then le
      check_count("cs low before strobe", quiet_span(run_start[i] - 1, -1),
                  (i == 0) ? 2 : 3);
    last = run_start.size() - 1;
    if (last >= 0)
      check_count("cs low after strobe", quiet_span(run_start[last] + run_len[last], 1), 1);
    check_word("memory word", model_word(addr_w'(5)), d);
    test_end("chip select edges", err0);
  endtask

  task automatic read_oete_test();
    logic [31:0]       v;
    logic [addr_w-1:0] a;
    logic [data_w-1:0] exp;
    logic [data_w-1:0] word;
    int                err0;
    err0 = errors;
    draw(addr_w, v);
    a   = v[addr_w-1:0];
    exp = model_word(a);
    set_cfg(1, 2, 1, 0);
    hist.delete();
    recording = 1'b1;
    issue(1'b1, a, '0);
    wait_done(word);
    recording = 1'b0;
    find_runs(1);
    check_count("mem_oe_n low spans", run_len.size(), lanes);
    foreach (run_len[i])
    begin
      check_count("mem_oe_n low cycles", run_len[i], 2);  // ws + 1 - oete
      check_count("cs low after mem_oe_n", quiet_span(run_start[i] + run_len[i], 1),
                  (i == lanes - 1) ? 1 : 2);
    end
    check_word("rdata", word, exp);
    test_end("read strobe early end", err0);
  endtask

  task automatic chain_test();
    logic [31:0]       v;
    logic [addr_w-1:0] a1;
    logic [addr_w-1:0] a2;
    logic [data_w-1:0] d1;
    logic [data_w-1:0] d2;
    logic [data_w-1:0] w1;
    logic [data_w-1:0] w2;
    int                err0;
    err0 = errors;
    draw(addr_w, v);
    a1 = v[addr_w-1:0];
    a2 = a1 ^ addr_w'(8);  // Other word of the model
    draw(data_w, v);
    d1 = v;
    draw(data_w, v);
    d2 = v;
    set_cfg(0, 3, 0, 0);
    for (int k = 0; k < 2; k++)  // Write pair, then read pair
    begin
      hist.delete();
      recording = 1'b1;
      issue(k == 1, a1, d1);
      wait_last_lane();
      issue(k == 1, a2, d2);
      wait_done(w1);
      wait_done(w2);
      recording = 1'b0;
      find_runs(2);
      check_count("mem_cs_n low spans", run_len.size(), 1);
    end
    check_word("first rdata", w1, d1);
    check_word("second rdata", w2, d2);
    test_end("chained access", err0);
  endtask

  // --------------------
  // Main sequence
  // --------------------
  initial
  begin
    req       = 1'b0;
    rd        = 1'b0;
    addr      = '0;
    wdata     = '0;
    cfg_csle  = '0;
    cfg_ws    = '0;
    cfg_oete  = '0;
    cfg_cste  = '0;
    recording = 1'b0;
    cycles    = 0;
    errors    = 0;
    checks    = 0;
    tests_run = 0;
    lfsr      = 16'd20066;
    for (int i = 0; i < 64; i++)
      mem[i] = 8'(i * 53 + 17);
    wait (n_sys_reset24 === 1'b1);
    @(posedge sys_clk24);
    #1;
    reset_state_test();
    write_read_test();
    wait_state_test();
    edge_timing_test();
    read_oete_test();
    chain_test();
    $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
    if (errors == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule

//--- bench/tb_clock.sv
`timescale 1ns/1ns
// Clock and reset source for the controller testbench
// 10 ns clock, reset low for the first two clock periods

module tb_clock
(
  output logic sys_clk24,
  output logic n_sys_reset24
);

  initial
  begin
    sys_clk24     = 1'b0;
    n_sys_reset24 = 1'b0;              // Held through two periods
    repeat (2) @(negedge sys_clk24);
    n_sys_reset24 = 1'b1;              // Released away from the rising edge
  end

  always #5 sys_clk24 = ~sys_clk24;    // 10 ns period

endmodule

//--- src/smc_lite.sv
`timescale 1ns/1ns
// Top level of the static memory controller
// Host word requests in, 8-bit asynchronous memory cycles out; timing
// comes from the cfg_ ports, sampled at the start of each access

module smc_lite
  import smc_pkg::*;
(
  input  logic                     sys_clk24,
  input  logic                     n_sys_reset24,
  input  logic                     req,         // Host request pulse
  input  logic                     rd,          // 1 for read
  input  logic [addr_w-1:0]        addr,
  input  logic [data_w-1:0]        wdata,
  output logic                     busy,
  output logic                     done,        // Word finished pulse
  output logic [data_w-1:0]        rdata,
  input  logic [edge_w-1:0]        cfg_csle,
  input  logic [ws_w-1:0]          cfg_ws,
  input  logic [edge_w-1:0]        cfg_oete,
  input  logic [edge_w-1:0]        cfg_cste,
  output logic                     mem_cs_n,
  output logic                     mem_oe_n,
  output logic                     mem_we_n,
  output logic [addr_w+lane_w-1:0] mem_addr,
  output logic [byte_w-1:0]        mem_wdata,
  input  logic [byte_w-1:0]        mem_rdata
);

  smc_timing_if tim ();
  smc_access_if acc ();

  logic smc_done;
  logic latch_data;
  logic smc_idle;
  logic r_cs_n;
  logic r_oe_n;
  logic r_we_n;
  logic r_cut_neg;  // Toggles mid-cycle at the end of a write lane
  logic r_cut_pos;  // Follows r_cut_neg on the next rising edge
  logic oe_end;     // Read strobe past its oete point

  smc_host_front front_i (.sys_clk24, .n_sys_reset24, .req, .rd, .addr, .wdata,
                          .busy, .acc(acc.front));

  smc_state state_i (.sys_clk24, .n_sys_reset24, .tim(tim.fsm), .acc(acc.fsm),
                     .smc_done, .latch_data, .smc_idle);

  smc_counters counters_i (.sys_clk24, .n_sys_reset24, .cfg_csle, .cfg_ws,
                           .cfg_oete, .cfg_cste, .tim(tim.cnt));

  smc_mac mac_i (.sys_clk24, .n_sys_reset24, .acc(acc.mac), .state(tim.state),
                 .smc_done, .latch_data, .mem_addr, .mem_wdata, .mem_rdata,
                 .rdata, .done);

  // --------------------
  // Memory strobes
  // --------------------
  // Lines up with the last latch_data cycle of the lane
  assign oe_end = (tim.state == st_rw) && (tim.r_ws_count != '0) &&
                  (tim.r_ws_count <= ws_w'(tim.r_oete_store));

  // Registered from the next state so the pins follow the state exactly
  always_ff @(posedge sys_clk24 or negedge n_sys_reset24)
  begin
    if (!n_sys_reset24)
    begin
      r_cs_n    <= 1'b1;
      r_oe_n    <= 1'b1;
      r_we_n    <= 1'b1;
      r_cut_pos <= 1'b0;
    end
    else
    begin
      r_cs_n    <= smc_idle || (tim.next_state == st_store);  // Low le to float
      r_oe_n    <= !(!acc.n_r_read && (tim.next_state == st_rw)) || oe_end;
      r_we_n    <= !(acc.n_r_read && (tim.next_state == st_rw));
      r_cut_pos <= r_cut_neg;
    end
  end

  // Write strobe rises half a cycle early so back-to-back rw lanes
  // still give the memory one rising edge per byte
  always_ff @(negedge sys_clk24 or negedge n_sys_reset24)
  begin
    if (!n_sys_reset24)
      r_cut_neg <= 1'b0;
    else if (acc.n_r_read && (tim.state == st_rw) && (tim.r_ws_count == '0))
      r_cut_neg <= !r_cut_neg;
  end

  assign mem_cs_n = r_cs_n;
  assign mem_oe_n = r_oe_n;
  assign mem_we_n = r_we_n || (r_cut_neg ^ r_cut_pos);

endmodule

//--- src/smc_mac.sv
`timescale 1ns/1ns
// Multiple-access control for 32-bit words on the 8-bit memory
// Steps the byte lanes, drives address and write byte, and packs read
// bytes back into a word, lane 0 in the low byte

module smc_mac
  import smc_pkg::*;
(
  input  logic                     sys_clk24,
  input  logic                     n_sys_reset24,
  smc_access_if.mac                acc,
  input  smc_state_e               state,
  input  logic                     smc_done,    // Byte cycle finished
  input  logic                     latch_data,  // Read data valid
  output logic [addr_w+lane_w-1:0] mem_addr,
  output logic [byte_w-1:0]        mem_wdata,
  input  logic [byte_w-1:0]        mem_rdata,
  output logic [data_w-1:0]        rdata,
  output logic                     done         // Word finished
);

  localparam logic [lane_w-1:0] last_lane = lane_w'(lanes - 1);

  logic [lane_w-1:0] r_lane;   // Current byte lane
  logic [addr_w-1:0] r_addr;   // Running word address
  logic [data_w-1:0] r_wdata;  // Running write word
  logic [data_w-1:0] r_rdata;  // Assembled read word
  logic              r_done;

  // --------------------
  // Lane sequencing
  // --------------------
  // Sits on the last lane between accesses so idle reads as done
  always_ff @(posedge sys_clk24 or negedge n_sys_reset24)
  begin
    if (!n_sys_reset24)
    begin
      r_lane <= last_lane;
      r_done <= 1'b0;
    end
    else
    begin
      r_done <= smc_done && acc.mac_done;  // One cycle after last lane
      if (acc.take)
        r_lane <= '0;
      else if (smc_done && !acc.mac_done)
        r_lane <= r_lane + 1'b1;
    end
  end

  // Access payload
  always_ff @(posedge sys_clk24)
  begin
    if (acc.take)
    begin
      r_addr  <= acc.addr;
      r_wdata <= acc.wdata;
    end
    if (latch_data && !acc.n_r_read)  // Reads only
      r_rdata[r_lane*byte_w +: byte_w] <= mem_rdata;
  end

  assign acc.mac_done = (r_lane == last_lane);
  assign mem_addr     = {r_addr, r_lane};
  // Write bus quiet in idle and during reads
  assign mem_wdata    = ((state == st_idle) || !acc.n_r_read) ? '0 :
                        r_wdata[r_lane*byte_w +: byte_w];
  assign rdata        = r_rdata;
  assign done         = r_done;

endmodule

//--- src/smc_counters.sv
`timescale 1ns/1ns
// Timing counters of the static memory controller
// Latches the configuration per access and counts the leading edge,
// wait states and trailing edge for the FSM

module smc_counters
  import smc_pkg::*;
(
  input  logic              sys_clk24,
  input  logic              n_sys_reset24,
  input  logic [edge_w-1:0] cfg_csle,   // Leading edge cycles
  input  logic [ws_w-1:0]   cfg_ws,     // Extra strobe cycles
  input  logic [edge_w-1:0] cfg_oete,   // Read strobe early end
  input  logic [edge_w-1:0] cfg_cste,   // Trailing edge cycles
  smc_timing_if.cnt         tim
);

  logic [edge_w-1:0] r_csle_count;
  logic [ws_w-1:0]   r_ws_count;
  logic [edge_w-1:0] r_cste_count;
  logic [edge_w-1:0] r_csle_store;
  logic [ws_w-1:0]   r_ws_store;    // Reload for later lanes
  logic [edge_w-1:0] r_oete_store;
  logic [edge_w-1:0] r_cste_store;  // Reload for later lanes

  // --------------------
  // Per-access store
  // --------------------
  always_ff @(posedge sys_clk24 or negedge n_sys_reset24)
  begin
    if (!n_sys_reset24)
    begin
      r_csle_store <= '0;
      r_ws_store   <= '0;
      r_oete_store <= '0;
      r_cste_store <= '0;
    end
    else if (tim.valid_access)  // Config sampled once per access
    begin
      r_csle_store <= cfg_csle;
      r_ws_store   <= cfg_ws;
      r_oete_store <= cfg_oete;
      r_cste_store <= cfg_cste;
    end
  end

  // --------------------
  // Down-counters
  // --------------------
  always_ff @(posedge sys_clk24 or negedge n_sys_reset24)
  begin
    if (!n_sys_reset24)
    begin
      r_csle_count <= '0;
      r_ws_count   <= '0;
      r_cste_count <= '0;
    end
    else if (tim.valid_access)
    begin
      r_csle_count <= cfg_csle;    // Straight from config
      r_ws_count   <= cfg_ws;
      r_cste_count <= cfg_cste;
    end
    else
    begin
      if (tim.le_enable)
        r_csle_count <= (tim.state == st_le) ? r_csle_count - 1'b1 : r_csle_store;
      if (tim.ws_enable)
      begin
        r_ws_count   <= r_ws_store;    // New lane
        r_cste_count <= r_cste_store;
      end
      else
      begin
        if ((tim.state == st_rw) && (r_ws_count != '0))
          r_ws_count <= r_ws_count - 1'b1;
        if (tim.cste_enable)
          r_cste_count <= r_cste_count - 1'b1;  // Counts into and through float
      end
    end
  end

  assign tim.r_csle_count = r_csle_count;
  assign tim.r_ws_count   = r_ws_count;
  assign tim.r_cste_count = r_cste_count;
  assign tim.r_csle_store = r_csle_store;
  assign tim.r_oete_store = r_oete_store;

endmodule

//--- src/smc_state.sv
`timescale 1ns/1ns
// Access timing FSM of the static memory controller
// Walks store, le, rw and float for each byte cycle and decodes the
// counter enables; back-to-back accesses skip idle and keep chip select

module smc_state
  import smc_pkg::*;
(
  input  logic      sys_clk24,
  input  logic      n_sys_reset24,
  smc_timing_if.fsm tim,
  smc_access_if.fsm acc,
  output logic      smc_done,    // Last cycle of a byte cycle
  output logic      latch_data,  // Read data window for the MAC
  output logic      smc_idle     // Heading for idle
);

  smc_state_e r_state;
  smc_state_e next_state;
  logic       ws_zero;       // Wait count expired
  logic       cste_zero;     // Trailing count expired
  logic       csle_used;     // Access has a leading edge
  logic       dir_change;    // Pending access turns the bus round
  logic       valid_access;

  assign ws_zero    = (tim.r_ws_count == '0);
  assign cste_zero  = (tim.r_cste_count == '0);
  assign csle_used  = (tim.r_csle_store != '0);
  assign dir_change = (acc.n_read != acc.n_r_read);

  // --------------------
  // Next state
  // --------------------
  always_comb
  begin
    next_state = st_idle;
    case (r_state)
      st_idle:
        if (acc.new_access)
          next_state = st_store;
      st_store:
        if (tim.r_csle_count != '0)
          next_state = st_le;
        else
          next_state = st_rw;
      st_le:
        if (tim.r_csle_count < 2'd2)  // Last leading edge cycle
          next_state = st_rw;
        else
          next_state = st_le;
      st_rw:
        if (!ws_zero)
          next_state = st_rw;         // Strobe still counting
        else if (!cste_zero)
          next_state = st_float;
        else if (!acc.mac_done)
          next_state = csle_used ? st_le : st_rw;  // Next lane
        else if (acc.new_access)
          next_state = dir_change ? st_store : st_rw;  // Chain
        else
          next_state = st_idle;
      st_float:
        if (!cste_zero)
          next_state = st_float;
        else if (!acc.mac_done)
          next_state = csle_used ? st_le : st_rw;
        else if (acc.new_access)
          next_state = dir_change ? st_store : st_rw;
        else
          next_state = st_idle;
      default:
        next_state = st_idle;
    endcase
  end

  always_ff @(posedge sys_clk24 or negedge n_sys_reset24)
  begin
    if (!n_sys_reset24)
      r_state <= st_idle;
    else
      r_state <= next_state;
  end

  // --------------------
  // Decodes
  // --------------------
  // Byte cycle ends in rw when there is no float, else in float
  assign smc_done = ((r_state == st_rw) && ws_zero && cste_zero) ||
                    ((r_state == st_float) && cste_zero);

  // Strobe tail, oete cycles before rw ends
  assign latch_data = (r_state == st_rw) &&
                      (tim.r_ws_count[edge_w-1:0] >= tim.r_oete_store) &&
                      (tim.r_ws_count[ws_w-1:edge_w] == '0);

  // Slot waiting and the running access on its final cycle, or idle
  assign valid_access = acc.new_access && acc.mac_done &&
                        ((r_state == st_idle) || smc_done);

  // csle counter runs in le, reloads on the way into a lane
  assign tim.le_enable = ((next_state == st_le) || (next_state == st_rw)) &&
                         (r_state != st_store);

  // Lane restart from rw or float within one access
  assign tim.ws_enable = !valid_access &&
                         ((next_state == st_le) || (next_state == st_rw)) &&
                         ((r_state == st_float) || ((r_state == st_rw) && ws_zero));

  assign tim.cste_enable  = (next_state == st_float);
  assign tim.valid_access = valid_access;
  assign tim.state        = r_state;
  assign tim.next_state   = next_state;
  assign acc.take         = valid_access && acc.new_access;
  assign smc_idle         = (next_state == st_idle);  // Front of idle

endmodule

//--- src/smc_host_front.sv
`timescale 1ns/1ns
// Host side of the controller
// Captures a request pulse into a one-entry slot until the FSM takes it

module smc_host_front
  import smc_pkg::*;
(
  input  logic              sys_clk24,
  input  logic              n_sys_reset24,
  input  logic              req,     // One cycle request pulse
  input  logic              rd,      // 1 for read
  input  logic [addr_w-1:0] addr,
  input  logic [data_w-1:0] wdata,
  output logic              busy,    // Slot occupied
  smc_access_if.front       acc
);

  logic              r_full;      // Slot holds a request
  logic              r_n_read;    // Active low read, pending request
  logic              r_n_r_read;  // Direction of last taken request
  logic [addr_w-1:0] r_addr;
  logic [data_w-1:0] r_wdata;
  logic              accept;      // Request lands in an empty slot

  assign accept = req && !r_full;  // Full slot ignores req

  // Slot and direction history
  always_ff @(posedge sys_clk24 or negedge n_sys_reset24)
  begin
    if (!n_sys_reset24)
    begin
      r_full     <= 1'b0;
      r_n_read   <= 1'b1;
      r_n_r_read <= 1'b1;
    end
    else if (acc.take)
    begin
      r_full     <= 1'b0;
      r_n_r_read <= r_n_read;  // Becomes the running direction
    end
    else if (accept)
    begin
      r_full   <= 1'b1;
      r_n_read <= ~rd;
    end
  end

  // Request payload
  always_ff @(posedge sys_clk24)
  begin
    if (accept)
    begin
      r_addr  <= addr;
      r_wdata <= wdata;
    end
  end

  assign acc.new_access = r_full;
  assign acc.n_read     = r_n_read;
  assign acc.n_r_read   = r_n_r_read;
  assign acc.addr       = r_addr;
  assign acc.wdata      = r_wdata;
  assign busy           = r_full;

endmodule

//--- src/smc_access_if.sv
`timescale 1ns/1ns
// Pending host access shared by the front end, the MAC and the FSM
// take moves the access out of the slot and into the MAC

interface smc_access_if
  import smc_pkg::*;
();

  logic              new_access;  // Slot full, access not started
  logic              n_read;      // Active low read, pending access
  logic              n_r_read;    // Direction latched at last take
  logic [addr_w-1:0] addr;        // Word address of pending access
  logic [data_w-1:0] wdata;       // Write word of pending access
  logic              take;        // FSM accepts the pending access
  logic              mac_done;    // Lane counter on last lane

  modport front (
    output new_access, n_read, n_r_read, addr, wdata,
    input  take
  );

  modport mac (
    input  addr, wdata, take, n_r_read,
    output mac_done
  );

  modport fsm (
    input  new_access, n_read, n_r_read, mac_done,
    output take
  );

endinterface

//--- src/smc_timing_if.sv
`timescale 1ns/1ns
// Counter values and counter enables between the FSM and the counters
// The top level also reads the state and counts for the strobes

interface smc_timing_if
  import smc_pkg::*;
();

  // From the counters
  logic [edge_w-1:0] r_csle_count;  // Leading edge remaining
  logic [ws_w-1:0]   r_ws_count;    // Wait states remaining
  logic [edge_w-1:0] r_cste_count;  // Trailing edge remaining
  logic [edge_w-1:0] r_csle_store;  // csle of current access
  logic [edge_w-1:0] r_oete_store;  // oete of current access

  // From the FSM
  logic       le_enable;     // Load or count the csle counter
  logic       ws_enable;     // Reload wait and trailing counts
  logic       cste_enable;   // Count the trailing edge
  logic       valid_access;  // New access loads configuration
  smc_state_e state;         // Registered state
  smc_state_e next_state;    // Decoded next state

  modport fsm (
    input  r_csle_count, r_ws_count, r_cste_count, r_csle_store, r_oete_store,
    output le_enable, ws_enable, cste_enable, valid_access, state, next_state
  );

  modport cnt (
    output r_csle_count, r_ws_count, r_cste_count, r_csle_store, r_oete_store,
    input  le_enable, ws_enable, cste_enable, valid_access, state
  );

endinterface

//--- src/smc_pkg.sv
// Shared types and sizes for the static memory controller
// Imported by every RTL module and both interfaces

package smc_pkg;

  // --------------------
  // Sizes
  // --------------------
  localparam int ws_w   = 8;              // Wait-state count width
  localparam int edge_w = 2;              // csle, oete and cste width
  localparam int lanes  = 4;              // Byte cycles per word
  localparam int lane_w = $clog2(lanes);  // Lane counter width
  localparam int addr_w = 24;             // External word address
  localparam int data_w = 32;             // Host word
  localparam int byte_w = 8;              // External data bus

  // --------------------
  // Controller states
  // --------------------
  // One-hot, five bits wide
  typedef enum logic [4:0] {
    st_idle  = 5'b00001,  // No access
    st_store = 5'b00010,  // Load timing, chip select still high
    st_le    = 5'b00100,  // Chip select leading edge
    st_rw    = 5'b01000,  // Strobe active
    st_float = 5'b10000   // Chip select trailing edge
  } smc_state_e;

endpackage
